//--- Makefile
SRCS := $(shell grep -v '^+' compile.f)

.PHONY: all run clean

all: run

obj_dir/Vcache_back_end_tb: compile.f $(SRCS)
	verilator --binary --timing -f compile.f --top-module cache_back_end_tb

run: obj_dir/Vcache_back_end_tb
	@out="$$(./obj_dir/Vcache_back_end_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^RESULT: PASS$$'

clean:
	rm -rf obj_dir

//--- bench/cache_back_end_tb.sv
`timescale 1ns/1ps

module cache_back_end_tb
   import cache_be_pkg::*;
;

   localparam int N_TESTS = 5;

   logic       clk_i;
   logic       rst_i;
   logic       write_valid_i;
   wr_req_t    write_req_i;
   logic       write_ready_o;
   logic       replace_valid_i;
   line_addr_t replace_addr_i;
   logic       replace_o;
   logic       read_valid_o;
   line_idx_t  read_idx_o;
   data_t      read_data_o;
   logic       be_avalid_o;
   be_req_t    be_req_o;
   logic       be_ready_i;
   logic       be_rvalid_i;
   data_t      be_rdata_i;
   logic       hold;

   int        checks;
   int        errors;
   int        test_err;
   string     test_name;
   logic      ready_low_seen;
   int        got_cnt;
   line_idx_t got_idx [8];
   data_t     got_data [8];

   tb_clock_gen clock_gen_i (
      .clk_o(clk_i),
      .rst_o(rst_i)
   );

   cache_back_end_top cache_back_end_top_i (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .write_valid_i  (write_valid_i),
      .write_req_i    (write_req_i),
      .write_ready_o  (write_ready_o),
      .replace_valid_i(replace_valid_i),
      .replace_addr_i (replace_addr_i),
      .replace_o      (replace_o),
      .read_valid_o   (read_valid_o),
      .read_idx_o     (read_idx_o),
      .read_data_o    (read_data_o),
      .be_avalid_o    (be_avalid_o),
      .be_req_o       (be_req_o),
      .be_ready_i     (be_ready_i),
      .be_rvalid_i    (be_rvalid_i),
      .be_rdata_i     (be_rdata_i)
   );

   tb_mem_model mem_i (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .hold_i     (hold),
      .be_avalid_i(be_avalid_o),
      .be_req_i   (be_req_o),
      .be_ready_o (be_ready_i),
      .be_rvalid_o(be_rvalid_i),
      .be_rdata_o (be_rdata_i)
   );

   task automatic check_data(input string name, input data_t exp, input data_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         test_err++;
         $display("ERR %s %s expected %h actual %h", test_name, name, exp, act);
      end
   endtask

   task automatic check_idx(input string name, input line_idx_t exp, input line_idx_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         test_err++;
         $display("ERR %s %s expected %0d actual %0d", test_name, name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      checks++;
      if (exp !== act) begin
         errors++;
         test_err++;
         $display("ERR %s %s expected %b actual %b", test_name, name, exp, act);
      end
   endtask

   // byte lanes with a set strobe take the new value.
   function automatic data_t merge_bytes(input data_t old, input data_t nw, input strb_t s);
      data_t r;
      r = old;
      for (int b = 0; b < NBYTES; b++) begin
         if (s[b]) begin
            r[8*b +: 8] = nw[8*b +: 8];
         end
      end
      return r;
   endfunction

   task automatic finish_test();
      if (test_err == 0) begin
         $display("test %s: ok", test_name);
      end else begin
         $display("test %s: %0d errors", test_name, test_err);
      end
      test_err = 0;
   endtask

   // called on a falling edge, returns on the falling edge after acceptance.
   task automatic push_write(input word_addr_t a, input data_t d, input strb_t s);
      write_valid_i    = 1'b1;
      write_req_i.addr = a;
      write_req_i.data = d;
      write_req_i.strb = s;
      while (!write_ready_o) begin
         ready_low_seen = 1'b1;
         @(negedge clk_i);
      end
      @(negedge clk_i);
      write_valid_i = 1'b0;
   endtask

   // the memory side counts as drained after 6 quiet cycles.
   task automatic wait_quiet();
      int quiet;
      quiet = 0;
      while (quiet < 6) begin
         @(negedge clk_i);
         quiet = be_avalid_o ? 0 : quiet + 1;
      end
   endtask

   task automatic run_refill(input line_addr_t line);
      got_cnt         = 0;
      replace_valid_i = 1'b1;
      replace_addr_i  = line;
      @(negedge clk_i);
      replace_valid_i = 1'b0;
      while (replace_o) begin
         if (read_valid_o && got_cnt < 8) begin
            got_idx[got_cnt]  = read_idx_o;
            got_data[got_cnt] = read_data_o;
            got_cnt++;
         end
         @(negedge clk_i);
      end
      check_flag("refill_end_valid", 1'b0, read_valid_o);
   endtask

   task automatic test_reset();
      test_name = "reset_state";
      @(negedge clk_i);
      while (rst_i) begin
         check_flag("reset_replace", 1'b0, replace_o);
         check_flag("reset_read_valid", 1'b0, read_valid_o);
         check_flag("reset_avalid", 1'b0, be_avalid_o);
         check_flag("reset_write_ready", 1'b1, write_ready_o);
         @(negedge clk_i);
      end
      check_flag("reset_replace", 1'b0, replace_o);
      check_flag("reset_read_valid", 1'b0, read_valid_o);
      check_flag("reset_avalid", 1'b0, be_avalid_o);
      check_flag("reset_write_ready", 1'b1, write_ready_o);
      finish_test();
   endtask

   task automatic test_single_write();
      data_t old;
      test_name = "single_write";
      old = mem_i.mem[8'h10];
      push_write(14'h0010, 32'h1122_3344, 4'b0101);
      wait_quiet();
      check_data("single_write", merge_bytes(old, 32'h1122_3344, 4'b0101), mem_i.mem[8'h10]);
      finish_test();
   endtask

   task automatic test_burst();
      int base;
      logic order_ok;
      test_name      = "buffered_burst";
      base           = mem_i.log_cnt;
      ready_low_seen = 1'b0;
      hold           = 1'b1;
      fork
         begin
            repeat (20) @(negedge clk_i);
            hold = 1'b0;
         end
      join_none
      for (int i = 0; i < 8; i++) begin
         push_write(14'h0040 + 14'(i), 32'hb000_0000 + 32'(i * 32'h0101_0101), 4'b1111);
      end
      wait_quiet();
      check_flag("burst_ready_drop", 1'b1, ready_low_seen);
      for (int i = 0; i < 8; i++) begin
         check_data("burst_data", 32'hb000_0000 + 32'(i * 32'h0101_0101),
                    mem_i.mem[8'h40 + 8'(i)]);
      end
      order_ok = (mem_i.log_cnt == base + 8);
      for (int i = 0; i < 8; i++) begin
         if (mem_i.log_addr[base + i] != 14'h0040 + 14'(i)) begin
            order_ok = 1'b0;
         end
      end
      if (!order_ok) begin
         $display("burst_order: memory did not see the writes in issue order");
      end
      check_flag("burst_order", 1'b1, order_ok);
      finish_test();
   endtask

   task automatic test_refill();
      test_name = "line_refill";
      run_refill(12'h005);
      check_flag("refill_count", 1'b1, got_cnt == 4);
      for (int k = 0; k < 4; k++) begin
         check_idx("refill_idx", line_idx_t'(k), got_idx[k]);
         check_data("refill_data", mem_i.mem[8'h14 + 8'(k)], got_data[k]);
      end
      finish_test();
   endtask

   task automatic test_ordering();
      data_t exp [4];
      test_name = "write_then_refill";
      for (int k = 0; k < 4; k++) begin
         exp[k] = mem_i.mem[8'h24 + 8'(k)];
      end
      exp[0] = merge_bytes(exp[0], 32'h0a0b_0c0d, 4'b1111);
      exp[1] = merge_bytes(exp[1], 32'h1a1b_1c1d, 4'b0011);
      exp[3] = merge_bytes(exp[3], 32'h3a3b_3c3d, 4'b1100);
      push_write(14'h0024, 32'h0a0b_0c0d, 4'b1111);
      push_write(14'h0025, 32'h1a1b_1c1d, 4'b0011);
      push_write(14'h0027, 32'h3a3b_3c3d, 4'b1100);
      run_refill(12'h009);
      check_flag("order_count", 1'b1, got_cnt == 4);
      for (int k = 0; k < 4; k++) begin
         check_idx("order_idx", line_idx_t'(k), got_idx[k]);
         check_data("order_data", exp[k], got_data[k]);
      end
      finish_test();
   endtask

   // budget of 200 cycles per test plus margin.
   initial begin
      repeat (N_TESTS * 200 + 1000) @(posedge clk_i);
      $display("timeout: the tests did not finish in the allowed cycles");
      $display("RESULT: FAIL");
      $finish;
   end

   initial begin
      write_valid_i   = 1'b0;
      write_req_i     = '0;
      replace_valid_i = 1'b0;
      replace_addr_i  = '0;
      hold            = 1'b0;
      checks          = 0;
      errors          = 0;
      test_err        = 0;
      test_name       = "";
      ready_low_seen  = 1'b0;
      got_cnt         = 0;
      test_reset();
      test_single_write();
      test_burst();
      test_refill();
      test_ordering();
      $display("tests: %0d, checks: %0d, errors: %0d", N_TESTS, checks, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk_o,
   output logic rst_o
);

   // 10 ns period.
   initial begin
      clk_o = 1'b0;
      forever #5 clk_o = ~clk_o;
   end

   // reset covers the first 4 rising edges and is released on a falling edge.
   initial begin
      rst_o = 1'b1;
      repeat (4) @(negedge clk_o);
      rst_o = 1'b0;
   end

endmodule

//--- bench/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model
   import cache_be_pkg::*;
(
   input  logic    clk_i,
   input  logic    rst_i,
   input  logic    hold_i,
   input  logic    be_avalid_i,
   input  be_req_t be_req_i,
   output logic    be_ready_o,
   output logic    be_rvalid_o,
   output data_t   be_rdata_o
);

   data_t      mem [256];
   word_addr_t log_addr [64];
   int         log_cnt;

   logic [31:0] lfsr;
   logic        accepted;
   logic        armed;
   logic [1:0]  stall;
   logic [1:0]  rd_cnt;
   logic [7:0]  rd_addr;

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return (s >> 1) ^ (s[0] ? 32'ha300_0000 : 32'h0);
   endfunction

   // two LFSR steps, one per stall bit.
   task automatic draw_stall(output logic [1:0] n);
      n[0] = lfsr[0];
      lfsr = lfsr_next(lfsr);
      n[1] = lfsr[0];
      lfsr = lfsr_next(lfsr);
   endtask

   // fill depends on the whole word index.
   initial begin
      for (int i = 0; i < 256; i++) begin
         mem[i] = {8'hc3, i[7:0], ~i[7:0], i[7:0] ^ 8'h5a};
      end
      log_cnt  = 0;
      lfsr     = 32'h1d44_e52e;
      accepted = 1'b0;
      armed    = 1'b0;
      stall    = 2'd0;
      rd_cnt   = 2'd0;
      rd_addr  = 8'd0;
      be_ready_o  <= 1'b0;
      be_rvalid_o <= 1'b0;
      be_rdata_o  <= '0;
   end

   // acceptance is seen on the rising edge.
   always @(posedge clk_i) begin
      if (!rst_i && be_avalid_i && be_ready_o) begin
         accepted = 1'b1;
         if (be_req_i.strb != 4'b0000) begin
            for (int b = 0; b < NBYTES; b++) begin
               if (be_req_i.strb[b]) begin
                  mem[be_req_i.addr[7:0]][8*b +: 8] = be_req_i.data[8*b +: 8];
               end
            end
            if (log_cnt < 64) begin
               log_addr[log_cnt] = be_req_i.addr;
            end
            log_cnt = log_cnt + 1;
         end else begin
            rd_addr = be_req_i.addr[7:0];
            rd_cnt  = 2'd2;
         end
      end
   end

   // outputs change on the falling edge.
   always @(negedge clk_i) begin
      if (rst_i) begin
         be_ready_o  <= 1'b0;
         be_rvalid_o <= 1'b0;
         be_rdata_o  <= '0;
         armed        = 1'b0;
      end else begin
         be_rvalid_o <= 1'b0;
         if (rd_cnt != 2'd0) begin
            rd_cnt = rd_cnt - 2'd1;
            if (rd_cnt == 2'd0) begin
               be_rvalid_o <= 1'b1;
               be_rdata_o  <= mem[rd_addr];
            end
         end
         if (accepted) begin
            accepted = 1'b0;
            armed    = 1'b0;
            be_ready_o <= 1'b0;
         end else if (be_avalid_i && !be_ready_o && !hold_i) begin
            if (!armed) begin
               armed = 1'b1;
               draw_stall(stall);
            end
            if (stall == 2'd0) begin
               be_ready_o <= 1'b1;
            end else begin
               stall = stall - 2'd1;
            end
         end
      end
   end

endmodule

//--- compile.f
design/cache_be_pkg.sv
design/cache_write_buffer.sv
design/cache_write_channel.sv
design/cache_read_channel.sv
design/cache_back_end.sv
design/cache_back_end_top.sv
bench/tb_clock_gen.sv
bench/tb_mem_model.sv
bench/cache_back_end_tb.sv

//--- design/cache_back_end.sv
`timescale 1ns/1ps

module cache_back_end
   import cache_be_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_i,

   input  logic       wbuf_empty_i,
   input  logic       wr_in_valid_i,
   input  wr_req_t    wr_in_req_i,
   output logic       wr_in_ready_o,

   input  logic       replace_valid_i,
   input  line_addr_t replace_addr_i,
   output logic       replace_o,
   output logic       read_valid_o,
   output line_idx_t  read_idx_o,
   output data_t      read_data_o,

   output logic       be_avalid_o,
   output be_req_t    be_req_o,
   input  logic       be_ready_i,
   input  logic       be_rvalid_i,
   input  data_t      be_rdata_i
);

   logic    wr_idle;
   logic    wr_ready;
   logic    wr_valid;
   be_req_t wr_req;
   logic    rd_valid;
   be_req_t rd_req;
   logic    rd_grant;
   logic    rd_grant_q;
   logic    wack;
   logic    wack_q;
   logic    ack;

   // a refill gets the port once the write side is drained, then keeps it.
   assign rd_grant = replace_o & (rd_grant_q | (wr_idle & wbuf_empty_i));

   // no new write starts while the refill owns the port.
   assign wr_in_ready_o = wr_ready & ~rd_grant;

   assign be_avalid_o = rd_valid | wr_valid;
   assign be_req_o    = rd_valid ? rd_req : wr_req;

   assign wack = be_avalid_o & be_ready_i & (|be_req_o.strb);
   assign ack  = be_rvalid_i | wack_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rd_grant_q <= 1'b0;
         wack_q     <= 1'b0;
      end else begin
         rd_grant_q <= rd_grant;
         wack_q     <= wack;
      end
   end

   cache_write_channel write_fsm (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .wr_valid_i(wr_in_valid_i & ~rd_grant),
      .wr_req_i  (wr_in_req_i),
      .wr_ready_o(wr_ready),
      .be_valid_o(wr_valid),
      .be_req_o  (wr_req),
      .be_ready_i(be_ready_i),
      .be_ack_i  (ack),
      .idle_o    (wr_idle)
   );

   cache_read_channel read_fsm (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .replace_valid_i(replace_valid_i),
      .replace_addr_i (replace_addr_i),
      .replace_o      (replace_o),
      .read_valid_o   (read_valid_o),
      .read_idx_o     (read_idx_o),
      .read_data_o    (read_data_o),
      .grant_i        (rd_grant),
      .be_valid_o     (rd_valid),
      .be_req_o       (rd_req),
      .be_ready_i     (be_ready_i),
      .be_ack_i       (ack),
      .be_rdata_i     (be_rdata_i)
   );

endmodule

//--- design/cache_back_end_top.sv
`timescale 1ns/1ps

module cache_back_end_top
   import cache_be_pkg::*;
#(
   parameter int WBUF_DEPTH_W = 2
) (
   input  logic       clk_i,
   input  logic       rst_i,

   input  logic       write_valid_i,
   input  wr_req_t    write_req_i,
   output logic       write_ready_o,

   input  logic       replace_valid_i,
   input  line_addr_t replace_addr_i,
   output logic       replace_o,
   output logic       read_valid_o,
   output line_idx_t  read_idx_o,
   output data_t      read_data_o,

   output logic       be_avalid_o,
   output be_req_t    be_req_o,
   input  logic       be_ready_i,
   input  logic       be_rvalid_i,
   input  data_t      be_rdata_i
);

   logic    wbuf_valid;
   wr_req_t wbuf_req;
   logic    wbuf_ready;
   logic    wbuf_empty;

   cache_write_buffer #(
      .WBUF_DEPTH_W(WBUF_DEPTH_W)
   ) write_buffer_i (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .in_valid_i (write_valid_i),
      .in_req_i   (write_req_i),
      .in_ready_o (write_ready_o),
      .out_valid_o(wbuf_valid),
      .out_req_o  (wbuf_req),
      .out_ready_i(wbuf_ready),
      .empty_o    (wbuf_empty)
   );

   cache_back_end back_end_i (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .wbuf_empty_i   (wbuf_empty),
      .wr_in_valid_i  (wbuf_valid),
      .wr_in_req_i    (wbuf_req),
      .wr_in_ready_o  (wbuf_ready),
      .replace_valid_i(replace_valid_i),
      .replace_addr_i (replace_addr_i),
      .replace_o      (replace_o),
      .read_valid_o   (read_valid_o),
      .read_idx_o     (read_idx_o),
      .read_data_o    (read_data_o),
      .be_avalid_o    (be_avalid_o),
      .be_req_o       (be_req_o),
      .be_ready_i     (be_ready_i),
      .be_rvalid_i    (be_rvalid_i),
      .be_rdata_i     (be_rdata_i)
   );

endmodule

//--- design/cache_be_pkg.sv
package cache_be_pkg;

   // widths of the memory side.
   localparam int ADDR_W       = 16;
   localparam int DATA_W       = 32;
   localparam int NBYTES       = 4;
   localparam int LINE_WORDS_W = 2;

   // word address drops the byte offset.
   typedef logic [ADDR_W-$clog2(NBYTES)-1:0] word_addr_t;

   // line address drops the word index as well.
   typedef logic [ADDR_W-$clog2(NBYTES)-LINE_WORDS_W-1:0] line_addr_t;

   typedef logic [LINE_WORDS_W-1:0] line_idx_t;
   typedef logic [DATA_W-1:0]       data_t;
   typedef logic [NBYTES-1:0]       strb_t;

   // one front-end write.
   typedef struct packed {
      word_addr_t addr;
      data_t      data;
      strb_t      strb;
   } wr_req_t;

   // one backend request, a zero strobe marks a read.
   typedef struct packed {
      word_addr_t addr;
      data_t      data;
      strb_t      strb;
   } be_req_t;

   typedef enum logic [1:0] {WR_IDLE, WR_REQ, WR_WAIT_ACK} wr_state_t;

   typedef enum logic [1:0] {RD_IDLE, RD_REQ, RD_WAIT_DATA, RD_DONE} rd_state_t;

endpackage

//--- design/cache_read_channel.sv
`timescale 1ns/1ps

module cache_read_channel
   import cache_be_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_i,

   input  logic       replace_valid_i,
   input  line_addr_t replace_addr_i,
   output logic       replace_o,

   output logic       read_valid_o,
   output line_idx_t  read_idx_o,
   output data_t      read_data_o,

   input  logic       grant_i,
   output logic       be_valid_o,
   output be_req_t    be_req_o,
   input  logic       be_ready_i,
   input  logic       be_ack_i,
   input  data_t      be_rdata_i
);

   rd_state_t  state;
   line_addr_t line_q;
   line_idx_t  idx_q;
   logic       last_word;

   assign replace_o  = (state != RD_IDLE);
   assign be_valid_o = (state == RD_REQ) & grant_i;
   assign last_word  = &idx_q;

   // word reads carry no strobe.
   always_comb begin
      be_req_o.addr = {line_q, idx_q};
      be_req_o.data = '0;
      be_req_o.strb = '0;
   end

   always_ff @(posedge clk_i) begin
      if (state == RD_IDLE && replace_valid_i) begin
         line_q <= replace_addr_i;
      end
   end

   // returned word and its index, one cycle after rvalid.
   always_ff @(posedge clk_i) begin
      if (state == RD_WAIT_DATA && be_ack_i) begin
         read_data_o <= be_rdata_i;
         read_idx_o  <= idx_q;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state        <= RD_IDLE;
         idx_q        <= '0;
         read_valid_o <= 1'b0;
      end else begin
         read_valid_o <= (state == RD_WAIT_DATA) & be_ack_i;
         case (state)
            RD_IDLE: begin
               idx_q <= '0;
               if (replace_valid_i) begin
                  state <= RD_REQ;
               end
            end
            RD_REQ: begin
               if (grant_i && be_ready_i) begin
                  state <= RD_WAIT_DATA;
               end
            end
            RD_WAIT_DATA: begin
               if (be_ack_i) begin
                  idx_q <= idx_q + 1'b1;
                  state <= last_word ? RD_DONE : RD_REQ;
               end
            end
            // last word is on the output here.
            RD_DONE: state <= RD_IDLE;
            default: state <= RD_IDLE;
         endcase
      end
   end

endmodule

//--- design/cache_write_buffer.sv
`timescale 1ns/1ps

module cache_write_buffer
   import cache_be_pkg::*;
#(
   parameter int WBUF_DEPTH_W = 2
) (
   input  logic    clk_i,
   input  logic    rst_i,

   input  logic    in_valid_i,
   input  wr_req_t in_req_i,
   output logic    in_ready_o,

   output logic    out_valid_o,
   output wr_req_t out_req_o,
   input  logic    out_ready_i,

   output logic    empty_o
);

   localparam int DEPTH = 2 ** WBUF_DEPTH_W;

   // count value of a full buffer.
   localparam logic [WBUF_DEPTH_W:0] FULL_CNT = {1'b1, {WBUF_DEPTH_W{1'b0}}};

   wr_req_t                 mem [DEPTH];
   logic [WBUF_DEPTH_W-1:0] wr_ptr;
   logic [WBUF_DEPTH_W-1:0] rd_ptr;
   logic [WBUF_DEPTH_W:0]   count;
   logic                    push;
   logic                    pop;

   assign in_ready_o  = (count != FULL_CNT);
   assign out_valid_o = (count != '0);
   assign empty_o     = (count == '0);
   assign out_req_o   = mem[rd_ptr];

   assign push = in_valid_i & in_ready_o;
   assign pop  = out_valid_o & out_ready_i;

   // storage only, no reset needed.
   always_ff @(posedge clk_i) begin
      if (push) begin
         mem[wr_ptr] <= in_req_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // push and pop together leave the count alone.
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

//--- design/cache_write_channel.sv
`timescale 1ns/1ps

module cache_write_channel
   import cache_be_pkg::*;
(
   input  logic    clk_i,
   input  logic    rst_i,

   input  logic    wr_valid_i,
   input  wr_req_t wr_req_i,
   output logic    wr_ready_o,

   output logic    be_valid_o,
   output be_req_t be_req_o,
   input  logic    be_ready_i,
   input  logic    be_ack_i,

   output logic    idle_o
);

   wr_state_t state;
   wr_req_t   req_q;

   assign wr_ready_o = (state == WR_IDLE);
   assign idle_o     = (state == WR_IDLE);
   assign be_valid_o = (state == WR_REQ);

   always_comb begin
      be_req_o.addr = req_q.addr;
      be_req_o.data = req_q.data;
      be_req_o.strb = req_q.strb;
   end

   // held write word.
   always_ff @(posedge clk_i) begin
      if (wr_valid_i && wr_ready_o) begin
         req_q <= wr_req_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state <= WR_IDLE;
      end else begin
         case (state)
            WR_IDLE: begin
               if (wr_valid_i) begin
                  state <= WR_REQ;
               end
            end
            WR_REQ: begin
               if (be_ready_i) begin
                  state <= WR_WAIT_ACK;
               end
            end
            // the ack comes one cycle after acceptance.
            WR_WAIT_ACK: begin
               if (be_ack_i) begin
                  state <= WR_IDLE;
               end
            end
            default: state <= WR_IDLE;
         endcase
      end
   end

endmodule
